// File: apple1_bus_pkg.sv
////////////////////
// apple1 system bus package
// widths, memory map and shared enums
////////////////////

package apple1_bus_pkg;

	// bus geometry
	localparam int addr_width = 16;  // full 64 KiB space
	localparam int data_width = 8;   // one byte per transfer

	// memory map, inclusive bounds
	localparam logic [addr_width-1:0] low_ram_top  = 16'h3FFF;  // low ram from 0000
	localparam logic [addr_width-1:0] basic_base   = 16'hE000;
	localparam logic [addr_width-1:0] basic_top    = 16'hEFFF;
	localparam logic [addr_width-1:0] monitor_base = 16'hFF00;  // runs to FFFF

	// array depths in bytes
	localparam int low_ram_words = 16384;
	localparam int basic_words   = 4096;
	localparam int monitor_words = 256;

	// decoded target of a request
	typedef enum logic [1:0] {
		region_low_ram  = 2'd0,
		region_basic    = 2'd1,
		region_monitor  = 2'd2,
		region_unmapped = 2'd3  // reads 00, writes dropped
	} mem_region_t;

	// registered bus operation
	typedef enum logic [1:0] {
		op_idle  = 2'd0,
		op_read  = 2'd1,  // cpu read
		op_write = 2'd2,  // cpu write
		op_load  = 2'd3   // loader write, may hit rom
	} bus_op_t;

endpackage

// File: apple1_bus_top.sv
////////////////////
// apple1 bus top
// request select, low ram, upper memory and read return
////////////////////

`timescale 1ns/100ps

module apple1_bus_top
	import apple1_bus_pkg::*;
(
	input  logic                  sys_clock,
	input  logic                  arst_n,
	// cpu port
	input  logic                  cpu_req,    // one-cycle strobe
	input  logic                  cpu_we,
	input  logic [addr_width-1:0] cpu_addr,
	input  logic [data_width-1:0] cpu_wdata,
	// loader port, wins over cpu
	input  logic                  load_wr,    // one-cycle strobe
	input  logic [addr_width-1:0] load_addr,
	input  logic [data_width-1:0] load_data,
	// read return
	output logic                  rd_valid,
	output logic [data_width-1:0] rd_data
);

	bus_op_t               req_op;       // registered request
	mem_region_t           req_region;
	logic [addr_width-1:0] req_addr;
	logic [data_width-1:0] req_data;
	logic [data_width-1:0] low_rdata;    // from low ram
	logic [data_width-1:0] upper_rdata;  // from basic / monitor

	bus_request_select u_select (
		.sys_clock  (sys_clock),
		.arst_n     (arst_n),
		.cpu_req    (cpu_req),
		.cpu_we     (cpu_we),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.load_wr    (load_wr),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.req_op     (req_op),
		.req_region (req_region),
		.req_addr   (req_addr),
		.req_data   (req_data)
	);

	low_ram u_low_ram (
		.sys_clock  (sys_clock),
		.req_op     (req_op),
		.req_region (req_region),
		.req_addr   (req_addr),
		.req_data   (req_data),
		.low_rdata  (low_rdata)
	);

	upper_memory u_upper (
		.sys_clock   (sys_clock),
		.req_op      (req_op),
		.req_region  (req_region),
		.req_addr    (req_addr),
		.req_data    (req_data),
		.upper_rdata (upper_rdata)
	);

	// one more stage, then the byte goes out
	read_return u_return (
		.sys_clock   (sys_clock),
		.arst_n      (arst_n),
		.req_op      (req_op),
		.req_region  (req_region),
		.low_rdata   (low_rdata),
		.upper_rdata (upper_rdata),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data)
	);

endmodule

// File: apple1_bus_trace.txt
# columns: test kind address byte, all hex except test
# kind L load, W cpu write, R cpu read (byte expected), B load plus cpu read
# test 1 loads into every mapped region, then reads back
1 L 0000 A9
1 L 0001 0F
1 L 3FFF 5C
1 L 1234 77
1 L E000 4C
1 L EFFF 3D
1 L FF00 D8
1 L FFFC 00
1 L FFFD FF
1 L FFFF 1F
1 R 0000 A9
1 R 0001 0F
1 R 3FFF 5C
1 R 1234 77
1 R E000 4C
1 R EFFF 3D
1 R FF00 D8
1 R FFFC 00
1 R FFFD FF
1 R FFFF 1F
# test 2 cpu writes to low and basic ram, some read the next cycle
2 W 0200 11
2 R 0200 11
2 W 0201 22
2 W E100 33
2 R 0201 22
2 R E100 33
2 W E101 44
2 R E101 44
2 W 0200 55
2 R 0200 55
2 W 2ABC 66
2 R 2ABC 66
# test 3 cpu writes to the monitor are dropped
3 L FF80 EA
3 W FF80 00
3 R FF80 EA
3 L FF81 60
3 W FF81 99
3 R FF81 60
# test 4 unmapped space reads 00
4 R C000 00
4 R 4000 00
4 W CC00 AB
4 R CC00 00
4 R F000 00
4 R FEFF 00
# test 5 back to back read burst
5 R 0000 A9
5 R E000 4C
5 R FF00 D8
5 R C000 00
5 R 0200 55
5 R FF80 EA
5 R 1234 77
5 R EFFF 3D
# test 6 load and cpu read in one cycle, load wins
6 B 0300 C3
6 B E200 5A
6 B FF90 B6
6 R 0300 C3
6 R E200 5A
6 R FF90 B6

// File: bus_request_select.sv
////////////////////
// bus request select
// loader over cpu, region decode, request register
////////////////////

`timescale 1ns/100ps

module bus_request_select
	import apple1_bus_pkg::*;
(
	input  logic                  sys_clock,
	input  logic                  arst_n,
	input  logic                  cpu_req,
	input  logic                  cpu_we,
	input  logic [addr_width-1:0] cpu_addr,
	input  logic [data_width-1:0] cpu_wdata,
	input  logic                  load_wr,
	input  logic [addr_width-1:0] load_addr,
	input  logic [data_width-1:0] load_data,
	output bus_op_t               req_op,
	output mem_region_t           req_region,
	output logic [addr_width-1:0] req_addr,
	output logic [data_width-1:0] req_data
);

	bus_op_t               next_op;
	mem_region_t           next_region;
	logic [addr_width-1:0] next_addr;
	logic [data_width-1:0] next_data;

	// map an address onto one of the four regions
	function automatic mem_region_t decode_region(input logic [addr_width-1:0] addr);
		mem_region_t region;
		if (addr <= low_ram_top)
			region = region_low_ram;
		else if (addr >= basic_base && addr <= basic_top)
			region = region_basic;
		else if (addr >= monitor_base)  // rom up to top of space
			region = region_monitor;
		else
			region = region_unmapped;  // old sdram, aci, vdp holes
		return region;
	endfunction

	// arbitration, loader has priority
	always_comb begin
		if (load_wr) begin
			next_op   = op_load;
			next_addr = load_addr;
			next_data = load_data;
		end else if (cpu_req) begin
			next_op   = cpu_we ? op_write : op_read;
			next_addr = cpu_addr;
			next_data = cpu_wdata;  // don't care on reads
		end else begin
			next_op   = op_idle;
			next_addr = cpu_addr;   // harmless, op is idle
			next_data = cpu_wdata;
		end
		next_region = decode_region(next_addr);
	end

	// control half of the request register
	always_ff @(posedge sys_clock or negedge arst_n) begin
		if (!arst_n) begin
			req_op     <= op_idle;
			req_region <= region_unmapped;
		end else begin
			req_op     <= next_op;
			req_region <= next_region;
		end
	end

	// address and data, payload only
	always_ff @(posedge sys_clock) begin
		req_addr <= next_addr;
		req_data <= next_data;
	end

endmodule

// File: low_ram.sv
////////////////////
// low system ram
// 16 KiB at 0000, registered read
////////////////////

`timescale 1ns/100ps

module low_ram
	import apple1_bus_pkg::*;
(
	input  logic                  sys_clock,
	input  bus_op_t               req_op,
	input  mem_region_t           req_region,
	input  logic [addr_width-1:0] req_addr,
	input  logic [data_width-1:0] req_data,
	output logic [data_width-1:0] low_rdata
);

	logic [data_width-1:0] mem [low_ram_words];  // contents survive reset
	logic                  wr_en;

	// cpu write or loader write, low region only
	assign wr_en = (req_region == region_low_ram) &&
	               (req_op == op_write || req_op == op_load);

	always_ff @(posedge sys_clock) begin
		if (wr_en)
			mem[req_addr[$clog2(low_ram_words)-1:0]] <= req_data;
	end

	// read every cycle, old data on a same-cycle write
	always_ff @(posedge sys_clock) begin
		low_rdata <= mem[req_addr[$clog2(low_ram_words)-1:0]];
	end

endmodule

// File: read_return.sv
////////////////////
// read return
// pairs read ops with memory data, one strobe out
////////////////////

`timescale 1ns/100ps

module read_return
	import apple1_bus_pkg::*;
(
	input  logic                  sys_clock,
	input  logic                  arst_n,
	input  bus_op_t               req_op,
	input  mem_region_t           req_region,
	input  logic [data_width-1:0] low_rdata,
	input  logic [data_width-1:0] upper_rdata,
	output logic                  rd_valid,
	output logic [data_width-1:0] rd_data
);

	logic        rd_pending;  // read waiting on memory data
	mem_region_t region_q;    // its region

	// stage 1 lines up with the memory read latch
	// stage 2 drives the strobe
	always_ff @(posedge sys_clock or negedge arst_n) begin
		if (!arst_n) begin
			rd_pending <= 1'b0;
			rd_valid   <= 1'b0;
		end else begin
			rd_pending <= (req_op == op_read);
			rd_valid   <= rd_pending;
		end
	end

	always_ff @(posedge sys_clock) begin
		region_q <= req_region;
		if (rd_pending) begin
			case (region_q)
				region_low_ram: rd_data <= low_rdata;
				region_basic,
				region_monitor: rd_data <= upper_rdata;
				default:        rd_data <= '0;  // unmapped reads 00
			endcase
		end
	end

endmodule

// File: sources.f
apple1_bus_pkg.sv
bus_request_select.sv
low_ram.sv
upper_memory.sv
read_return.sv
apple1_bus_top.sv
tb_apple1_bus_props.sv
tb_apple1_bus.sv

// File: tb_apple1_bus.sv
////////////////////
// apple1 bus testbench
// trace driven loads, cpu reads and writes, read checks
////////////////////

`timescale 1ns/100ps

module tb_apple1_bus
	import apple1_bus_pkg::*;
();

	logic                  sys_clock;
	logic                  arst_n;
	logic                  cpu_req;
	logic                  cpu_we;
	logic [addr_width-1:0] cpu_addr;
	logic [data_width-1:0] cpu_wdata;
	logic                  load_wr;
	logic [addr_width-1:0] load_addr;
	logic [data_width-1:0] load_data;
	logic                  rd_valid;
	logic [data_width-1:0] rd_data;

	integer seed = 76517;          // idle gap generator
	int     error_count = 0;
	int     check_count = 0;
	int     test_count = 0;
	int     cycle_count = 0;       // rising edges seen so far
	logic   timed_out = 1'b0;

	logic [data_width-1:0] exp_data_q [$];  // expected bytes, request order
	int                    due_cycle_q [$]; // cycle each strobe must show up
	logic [data_width-1:0] head_data;
	int                    head_due;

	apple1_bus_top UUT (
		.sys_clock (sys_clock),
		.arst_n    (arst_n),
		.cpu_req   (cpu_req),
		.cpu_we    (cpu_we),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.load_wr   (load_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

	// 8 ns clock
	initial begin
		sys_clock = 1'b0;
		forever #4 sys_clock = ~sys_clock;
	end

	always @(posedge sys_clock)
		cycle_count = cycle_count + 1;

	// compare one value, report on mismatch
	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED: %s got %0h expected %0h", name, actual, expected);
		end
	endtask

	// read checker, outputs sampled mid cycle
	always @(negedge sys_clock) begin
		if (arst_n && rd_valid === 1'b1) begin
			if (exp_data_q.size() == 0) begin
				error_count++;
				$display("rd_valid high at cycle %0d with no read outstanding", cycle_count);
			end else begin
				head_data = exp_data_q.pop_front();
				head_due  = due_cycle_q.pop_front();
				check_value("rd_data", rd_data, head_data);
				check_value("rd_valid cycle", cycle_count, head_due);
			end
		end
	end

	// all strobes low
	task automatic drive_idle();
		@(posedge sys_clock);
		#1;
		cpu_req = 1'b0;
		cpu_we  = 1'b0;
		load_wr = 1'b0;
	endtask

	// one trace line on the bus for one cycle
	task automatic drive_op(input logic [7:0] kind, input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data);
		@(posedge sys_clock);
		#1;
		cpu_req = 1'b0;
		cpu_we  = 1'b0;
		load_wr = 1'b0;
		case (kind)
			"L": begin
				load_wr   = 1'b1;
				load_addr = addr;
				load_data = data;
			end
			"W": begin
				cpu_req   = 1'b1;
				cpu_we    = 1'b1;
				cpu_addr  = addr;
				cpu_wdata = data;
			end
			"R": begin
				cpu_req  = 1'b1;
				cpu_addr = addr;
				exp_data_q.push_back(data);
				due_cycle_q.push_back(cycle_count + 3);  // sampled next edge, then two more
			end
			"B": begin  // loader wins, read is lost
				load_wr   = 1'b1;
				load_addr = addr;
				load_data = data;
				cpu_req   = 1'b1;
				cpu_addr  = addr;
			end
			default: begin
				error_count++;
				$display("trace line has unknown kind %c", kind);
			end
		endcase
	endtask

	// drain reads, report the test, random idle gap
	task automatic finish_test(input int test_num, input int errors_before,
		input int checks_before);
		int waited;
		int gap;
		drive_idle();
		waited = 0;
		while (exp_data_q.size() != 0 && waited < 32) begin
			@(posedge sys_clock);
			waited++;
		end
		if (exp_data_q.size() != 0) begin
			timed_out = 1'b1;
			$display("timeout in test %0d, %0d reads never returned", test_num,
				exp_data_q.size());
		end else begin
			repeat (3) @(posedge sys_clock);  // a stray strobe lands here
		end
		test_count++;
		$display("test %0d %s: %0d checks, %0d errors", test_num,
			(error_count == errors_before && !timed_out) ? "passed" : "failed",
			check_count - checks_before, error_count - errors_before);
		gap = $random(seed) & 3;  // 0 to 3 idle cycles
		repeat (gap) @(posedge sys_clock);
	endtask

	initial begin
		int                    fd;
		int                    fields;
		int                    test_num;
		int                    cur_test;
		int                    errors_before;
		int                    checks_before;
		logic [7:0]            kind;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] data;
		logic [8*96-1:0]       line_buf;
		arst_n    = 1'b0;
		cpu_req   = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		load_wr   = 1'b0;
		load_addr = '0;
		load_data = '0;
		cur_test      = -1;
		errors_before = 0;
		checks_before = 0;
		repeat (16) @(posedge sys_clock);
		#1 arst_n = 1'b1;
		@(negedge sys_clock);
		check_value("rd_valid after reset", rd_valid, 0);
		fd = $fopen("apple1_bus_trace.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("could not open the trace file apple1_bus_trace.txt");
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line_buf = '0;
				if ($fgets(line_buf, fd) == 0)
					continue;
				fields = $sscanf(line_buf, "%d %c %h %h", test_num, kind, addr, data);
				if (fields != 4)
					continue;  // comment or blank line
				if (test_num != cur_test) begin
					if (cur_test >= 0)
						finish_test(cur_test, errors_before, checks_before);
					cur_test      = test_num;
					errors_before = error_count;
					checks_before = check_count;
				end
				if (!timed_out)
					drive_op(kind, addr, data);
			end
			if (cur_test >= 0 && !timed_out)
				finish_test(cur_test, errors_before, checks_before);
			$fclose(fd);
		end
		// bound assertion failures count as errors too
		error_count = error_count + UUT.u_return.u_props.fail_count;
		$display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
			error_count);
		if (error_count == 0 && !timed_out)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: tb_apple1_bus_props.sv
////////////////////
// read return properties
// request to strobe timing
////////////////////

`timescale 1ns/100ps

module tb_apple1_bus_props
	import apple1_bus_pkg::*;
(
	input logic    sys_clock,
	input logic    arst_n,
	input bus_op_t req_op,
	input logic    rd_valid
);

	int fail_count = 0;  // failed assertions so far

	// strobe never X or Z out of reset
	valid_known: assert property (
		@(posedge sys_clock) disable iff (!arst_n)
		!$isunknown(rd_valid)
	) else begin
		fail_count++;
		$error("rd_valid is unknown");
	end

	// registered read shows up two edges on
	read_gives_valid: assert property (
		@(posedge sys_clock) disable iff (!arst_n)
		(req_op == op_read) |-> ##2 rd_valid
	) else begin
		fail_count++;
		$error("read request without rd_valid");
	end

	// no strobe without a read behind it
	valid_from_read: assert property (
		@(posedge sys_clock) disable iff (!arst_n)
		rd_valid |-> ($past(req_op, 2) == op_read)
	) else begin
		fail_count++;
		$error("rd_valid without a read request");
	end

endmodule

bind read_return tb_apple1_bus_props u_props (
	.sys_clock (sys_clock),
	.arst_n    (arst_n),
	.req_op    (req_op),
	.rd_valid  (rd_valid)
);

// File: upper_memory.sv
////////////////////
// upper memory
// basic ram at E000 and monitor rom at FF00
////////////////////

`timescale 1ns/100ps

module upper_memory
	import apple1_bus_pkg::*;
(
	input  logic                  sys_clock,
	input  bus_op_t               req_op,
	input  mem_region_t           req_region,
	input  logic [addr_width-1:0] req_addr,
	input  logic [data_width-1:0] req_data,
	output logic [data_width-1:0] upper_rdata
);

	logic [data_width-1:0] basic_mem   [basic_words];
	logic [data_width-1:0] monitor_mem [monitor_words];  // wozmon image from loader

	logic basic_wr;
	logic monitor_wr;
	logic any_wr;    // write or load op

	logic [$clog2(basic_words)-1:0]   basic_idx;
	logic [$clog2(monitor_words)-1:0] monitor_idx;

	assign any_wr      = (req_op == op_write) || (req_op == op_load);
	assign basic_idx   = req_addr[$clog2(basic_words)-1:0];
	assign monitor_idx = req_addr[$clog2(monitor_words)-1:0];

	// basic takes both masters
	assign basic_wr = any_wr && (req_region == region_basic);

	// rom is writable by the loader only, cpu writes vanish
	assign monitor_wr = (req_op == op_load) && (req_region == region_monitor);

	always_ff @(posedge sys_clock) begin
		if (basic_wr)
			basic_mem[basic_idx] <= req_data;
	end

	always_ff @(posedge sys_clock) begin
		if (monitor_wr)
			monitor_mem[monitor_idx] <= req_data;
	end

	// byte of the array the region points at
	// non-upper regions just fetch basic, read_return ignores it
	always_ff @(posedge sys_clock) begin
		if (req_region == region_monitor)
			upper_rdata <= monitor_mem[monitor_idx];
		else
			upper_rdata <= basic_mem[basic_idx];
	end

endmodule
